// File: verilog.f
hdl/gem_pkg.sv
hdl/csc_pkg.sv
hdl/gem_cluster_intake.sv
hdl/gem_roll_wg_lut.sv
hdl/gem_csc_wg_matcher.sv
hdl/gem_csc_match_out.sv
hdl/gem_csc_wg_match_top.sv
verification/gem_csc_wg_match_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the GEM/CSC wiregroup match testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module gem_csc_wg_match_tb --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vgem_csc_wg_match_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx 'TB PASSED'; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: verification/gem_csc_wg_match_tb.sv
`default_nettype none

module gem_csc_wg_match_tb
	import gem_pkg::*;
	import csc_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          MARGIN = 2;
	localparam int          HOLD   = 4;
	localparam int          N_ROWS = 25;
	localparam int unsigned SEED   = 32'hd9d5_aae6;

	typedef struct packed {
		logic       send_alct;
		wg_t        keywire;
		logic       rand_kw;
		logic [2:0] gap;
		logic       odd;
		roll_t      roll;
		logic       wr;
		roll_t      wr_adr;
		wg_t        wr_data;
		logic       new_alct;
		wg_t        new_kw;
	} row_t;

	// Send ALCT, keywire, random keywire, gap, odd, roll, write, w_adr, w_data, new ALCT, new keywire
	row_t rows [N_ROWS] = '{
		'{1'b0, 7'd0,   1'b0, 3'd0, 1'b1, 3'd0, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd0,   1'b1, 3'd0, 1'b1, 3'd0, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd0,   1'b1, 3'd1, 1'b1, 3'd2, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd0,   1'b1, 3'd2, 1'b1, 3'd5, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd0,   1'b1, 3'd0, 1'b1, 3'd7, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd60,  1'b0, 3'd0, 1'b1, 3'd1, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd16,  1'b0, 3'd0, 1'b0, 3'd4, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd0,   1'b1, 3'd1, 1'b0, 3'd6, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd17,  1'b0, 3'd0, 1'b0, 3'd7, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd0,   1'b1, 3'd0, 1'b1, 3'd4, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd0,   1'b1, 3'd2, 1'b1, 3'd6, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd35,  1'b0, 3'd0, 1'b0, 3'd3, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd25,  1'b0, 3'd1, 1'b0, 3'd5, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd20,  1'b0, 3'd0, 1'b1, 3'd3, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd19,  1'b0, 3'd0, 1'b1, 3'd3, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd35,  1'b0, 3'd0, 1'b1, 3'd3, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd36,  1'b0, 3'd0, 1'b1, 3'd3, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd127, 1'b0, 3'd0, 1'b1, 3'd0, 1'b1, 3'd0, 7'd126, 1'b0, 7'd0},
		'{1'b1, 7'd123, 1'b0, 3'd0, 1'b0, 3'd0, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd0,   1'b0, 3'd0, 1'b0, 3'd1, 1'b1, 3'd1, 7'd1,   1'b0, 7'd0},
		'{1'b1, 7'd3,   1'b0, 3'd0, 1'b1, 3'd1, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd30,  1'b0, 3'd3, 1'b1, 3'd2, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd30,  1'b0, 3'd4, 1'b1, 3'd2, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b0, 7'd0,   1'b0, 3'd0, 1'b1, 3'd2, 1'b0, 3'd0, 7'd0,   1'b0, 7'd0},
		'{1'b1, 7'd60,  1'b0, 3'd3, 1'b1, 3'd2, 1'b0, 3'd0, 7'd0,   1'b1, 7'd30}
	};

	logic          clock = 1'b0;
	logic          arst_n;
	logic          alct_valid;
	alct_t         alct;
	logic          cluster_valid;
	gem_cluster_t  cluster;
	logic          lut_wen;
	roll_t         lut_addr;
	wg_t           lut_data;
	logic          result_valid;
	match_result_t result;
	match_count_t  match_count;

	// Reference copy of the station tables
	wg_t m_odd_low  [8] = '{7'd37, 7'd31, 7'd27, 7'd22, 7'd19, 7'd15, 7'd11, 7'd8};
	wg_t m_odd_high [8] = '{7'd47, 7'd44, 7'd38, 7'd33, 7'd28, 7'd23, 7'd19, 7'd15};
	wg_t m_even_low [8] = '{7'd37, 7'd31, 7'd27, 7'd22, 7'd17, 7'd13, 7'd10, 7'd6};
	wg_t m_even_high[8] = '{7'd47, 7'd44, 7'd38, 7'd32, 7'd27, 7'd22, 7'd17, 7'd14};

	int           step = 0;
	int           cycles = 0;
	int           cycle_limit = 0;
	int           errors = 0;
	int           checks = 0;
	logic         have_alct = 1'b0;
	int           held_step = 0;
	wg_t          held_kw = '0;
	match_count_t exp_count = '0;

	gem_csc_wg_match_top #(
		.MATCH_MARGIN(MARGIN),
		.ALCT_HOLD   (HOLD)
	) dut (.*);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the rows did not complete", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// Inputs change 2 ns after the edge and default to idle
	task automatic next_cycle();
		@(posedge clock);
		#2;
		step          = step + 1;
		alct_valid    = 1'b0;
		cluster_valid = 1'b0;
		lut_wen       = 1'b0;
	endtask

	task automatic drive_alct(input wg_t kw);
		alct_valid   = 1'b1;
		alct.keywire = kw;
		have_alct    = 1'b1;
		held_step    = step;
		held_kw      = kw;
	endtask

	function automatic wg_t random_keywire(input logic odd, input roll_t roll);
		int          lo;
		int          hi;
		int unsigned r;
		lo = odd ? int'(m_odd_low[roll]) : int'(m_even_low[roll]);
		hi = odd ? int'(m_odd_high[roll]) : int'(m_even_high[roll]);
		r  = $urandom;
		return wg_t'(lo + int'(r % (hi - lo + 1)));
	endfunction

	function automatic match_result_t expected_result(input logic odd, input roll_t roll,
		input wg_t kw);
		match_result_t e;
		int            lo;
		int            hi;
		lo = odd ? int'(m_odd_low[roll]) : int'(m_even_low[roll]);
		hi = odd ? int'(m_odd_high[roll]) : int'(m_even_high[roll]);
		lo = (lo - MARGIN < 0) ? 0 : lo - MARGIN;
		hi = (hi + MARGIN > 127) ? 127 : hi + MARGIN;
		e.matched     = (int'(kw) >= lo) && (int'(kw) <= hi);
		e.roll        = roll;
		e.odd         = odd;
		e.keywire     = kw;
		e.window.low  = wg_t'(lo);
		e.window.high = wg_t'(hi);
		return e;
	endfunction

	task automatic check_result(input match_result_t got, input match_result_t exp,
		input string tag);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0d ns: %s got m=%0b r=%0d o=%0b kw=%0d w=%0d..%0d",
				$time, tag, got.matched, got.roll, got.odd, got.keywire,
				got.window.low, got.window.high,
				", expected m=%0b r=%0d o=%0b kw=%0d w=%0d..%0d",
				exp.matched, exp.roll, exp.odd, exp.keywire, exp.window.low, exp.window.high);
		end
	endtask

	task automatic check_count(input match_count_t got, input match_count_t exp,
		input string tag);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0d ns: %s match_count %0d, expected %0d", $time, tag, got, exp);
		end
	endtask

	task automatic run_row(input row_t r, input int idx);
		int            gap;
		int            i;
		int            waited;
		int            cl_step;
		logic          paired;
		logic          seen;
		wg_t           kw;
		match_result_t exp;
		string         tag;
		tag = $sformatf("row %0d", idx);
		gap = int'(r.gap);
		if (r.wr) begin
			lut_wen  = 1'b1;
			lut_addr = r.wr_adr;
			lut_data = r.wr_data;
			// A write lands in all four tables
			m_odd_low[r.wr_adr]   = r.wr_data;
			m_odd_high[r.wr_adr]  = r.wr_data;
			m_even_low[r.wr_adr]  = r.wr_data;
			m_even_high[r.wr_adr] = r.wr_data;
			next_cycle();
		end
		kw = r.rand_kw ? random_keywire(r.odd, r.roll) : r.keywire;
		cl_step = 0;
		for (i = 0; i <= gap; i++) begin
			if (i == 0 && r.send_alct) begin
				drive_alct(kw);
			end
			if (r.new_alct && i == gap - 1) begin
				drive_alct(r.new_kw);
			end
			if (i == gap) begin
				cluster_valid = 1'b1;
				cluster.odd   = r.odd;
				cluster.roll  = r.roll;
				cl_step       = step;
			end
			next_cycle();
		end
		paired = have_alct && (cl_step - held_step >= 0) && (cl_step - held_step < HOLD);
		exp = expected_result(r.odd, r.roll, held_kw);
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < 5) begin
			next_cycle();
			waited++;
			seen = result_valid;
		end
		if (paired && !seen) begin
			errors++;
			$display("%s: no result_valid within 5 cycles of the cluster", tag);
		end else if (!paired && seen) begin
			errors++;
			$display("%s: result_valid for a cluster without a held ALCT", tag);
		end else if (seen && waited != 3) begin
			errors++;
			$display("%s: result_valid came %0d cycles after the cluster, not 3", tag, waited);
		end
		if (paired && seen) begin
			check_result(result, exp, tag);
			// Counter stops at full scale
			if (exp.matched && exp_count < 16'hffff) begin
				exp_count = exp_count + 1'b1;
			end
		end
		check_count(match_count, exp_count, tag);
		$display("%s finished with %s, %0d errors so far", tag,
			paired ? "a result" : "no result", errors);
	endtask

	initial begin
		int i;
		int p;
		int max_p;
		void'($urandom(SEED));
		arst_n        = 1'b0;
		alct_valid    = 1'b0;
		alct          = '0;
		cluster_valid = 1'b0;
		cluster       = '0;
		lut_wen       = 1'b0;
		lut_addr      = '0;
		lut_data      = '0;
		// Longest input phase of a row, then 3 cycles latency and 2 spare
		max_p = 0;
		for (i = 0; i < N_ROWS; i++) begin
			p = int'(rows[i].wr) + int'(rows[i].gap) + 1;
			if (p > max_p) begin
				max_p = p;
			end
		end
		cycle_limit = N_ROWS * (max_p + 3 + 2) + 20;
		repeat (5) @(posedge clock);
		#2;
		arst_n = 1'b1;
		checks++;
		if (result_valid !== 1'b0) begin
			errors++;
			$display("result_valid is not low after reset");
		end
		check_count(match_count, '0, "reset");
		for (i = 0; i < N_ROWS; i++) begin
			run_row(rows[i], i);
		end
		$display("%0d rows, %0d checks, %0d errors", N_ROWS, checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/gem_csc_wg_match_top.sv
`default_nettype none

module gem_csc_wg_match_top
	import gem_pkg::*;
	import csc_pkg::*;
#(
	parameter int MATCH_MARGIN = 2,
	parameter int ALCT_HOLD    = 4
) (
	input  logic          clock,
	input  logic          arst_n,
	input  logic          alct_valid,
	input  alct_t         alct,
	input  logic          cluster_valid,
	input  gem_cluster_t  cluster,
	input  logic          lut_wen,
	input  roll_t         lut_addr,
	input  wg_t           lut_data,
	output logic          result_valid,
	output match_result_t result,
	output match_count_t  match_count
);

	logic          rd_odd;
	logic          rd_even;
	roll_t         rd_adr;
	logic          req_valid;
	match_req_t    req;
	wg_t           wg_low;
	wg_t           wg_high;
	logic          res_valid;
	match_result_t res;

	gem_cluster_intake #(
		.ALCT_HOLD(ALCT_HOLD)
	) u_intake (
		.clock        (clock),
		.arst_n       (arst_n),
		.alct_valid   (alct_valid),
		.alct         (alct),
		.cluster_valid(cluster_valid),
		.cluster      (cluster),
		.rd_odd       (rd_odd),
		.rd_even      (rd_even),
		.rd_adr       (rd_adr),
		.req_valid    (req_valid),
		.req          (req)
	);

	// Same roll addresses both low and high tables
	gem_roll_wg_lut u_lut (
		.clock  (clock),
		.arst_n (arst_n),
		.wen    (lut_wen),
		.w_adr  (lut_addr),
		.w_data (lut_data),
		.renodd (rd_odd),
		.reneven(rd_even),
		.r_adr1 (rd_adr),
		.r_adr2 (rd_adr),
		.r_data1(wg_low),
		.r_data2(wg_high)
	);

	gem_csc_wg_matcher #(
		.MATCH_MARGIN(MATCH_MARGIN)
	) u_matcher (
		.clock    (clock),
		.arst_n   (arst_n),
		.req_valid(req_valid),
		.req      (req),
		.wg_low   (wg_low),
		.wg_high  (wg_high),
		.res_valid(res_valid),
		.res      (res)
	);

	gem_csc_match_out u_out (
		.clock       (clock),
		.arst_n      (arst_n),
		.res_valid   (res_valid),
		.res         (res),
		.result_valid(result_valid),
		.result      (result),
		.match_count (match_count)
	);

endmodule

`default_nettype wire

// File: hdl/gem_csc_match_out.sv
`default_nettype none

module gem_csc_match_out
	import csc_pkg::*;
(
	input  logic          clock,
	input  logic          arst_n,
	input  logic          res_valid,
	input  match_result_t res,
	output logic          result_valid,
	output match_result_t result,
	output match_count_t  match_count
);

	logic count_en;

	assign count_en = res_valid && res.matched && (match_count != '1);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= res_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (res_valid) begin
			result <= res;
		end
	end

	// Sticks at full scale
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			match_count <= '0;
		end else if (count_en) begin
			match_count <= match_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/gem_csc_wg_matcher.sv
`default_nettype none

module gem_csc_wg_matcher
	import csc_pkg::*;
#(
	parameter int MATCH_MARGIN = 2
) (
	input  logic          clock,
	input  logic          arst_n,
	input  logic          req_valid,
	input  match_req_t    req,
	input  wg_t           wg_low,
	input  wg_t           wg_high,
	output logic          res_valid,
	output match_result_t res
);

	localparam logic [7:0] MARGIN = 8'(MATCH_MARGIN);

	logic       req_d_valid;
	match_req_t req_d;
	logic [7:0] high_sum;
	wg_window_t window;
	logic       matched;

	// Table data shows up one edge after the request
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			req_d_valid <= 1'b0;
		end else begin
			req_d_valid <= req_valid;
		end
	end

	always_ff @(posedge clock) begin
		req_d <= req;
	end

	// Widened window, clamped to 0 and WG_MAX
	always_comb begin
		high_sum = {1'b0, wg_high} + MARGIN;
		if ({1'b0, wg_low} >= MARGIN) begin
			window.low = wg_t'({1'b0, wg_low} - MARGIN);
		end else begin
			window.low = '0;
		end
		window.high = (high_sum > {1'b0, WG_MAX}) ? WG_MAX : high_sum[6:0];
		matched = (req_d.keywire >= window.low) && (req_d.keywire <= window.high);
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= req_d_valid;
		end
	end

	always_ff @(posedge clock) begin
		res.matched <= matched;
		res.roll    <= req_d.cluster.roll;
		res.odd     <= req_d.cluster.odd;
		res.keywire <= req_d.keywire;
		res.window  <= window;
	end

endmodule

`default_nettype wire

// File: hdl/gem_roll_wg_lut.sv
`default_nettype none

module gem_roll_wg_lut
	import gem_pkg::*;
	import csc_pkg::*;
(
	input  logic  clock,
	input  logic  arst_n,
	input  logic  wen,
	input  roll_t w_adr,
	input  wg_t   w_data,
	input  logic  renodd,
	input  logic  reneven,
	input  roll_t r_adr1,
	input  roll_t r_adr2,
	output wg_t   r_data1,
	output wg_t   r_data2
);

	// Station defaults, roll 0 first
	wg_t odd_low [NUM_ROLLS] = '{
		7'd37, 7'd31, 7'd27, 7'd22, 7'd19, 7'd15, 7'd11, 7'd8
	};
	wg_t odd_high [NUM_ROLLS] = '{
		7'd47, 7'd44, 7'd38, 7'd33, 7'd28, 7'd23, 7'd19, 7'd15
	};
	wg_t even_low [NUM_ROLLS] = '{
		7'd37, 7'd31, 7'd27, 7'd22, 7'd17, 7'd13, 7'd10, 7'd6
	};
	wg_t even_high [NUM_ROLLS] = '{
		7'd47, 7'd44, 7'd38, 7'd32, 7'd27, 7'd22, 7'd17, 7'd14
	};

	// One write lands in all four tables
	always_ff @(posedge clock) begin
		if (wen) begin
			odd_low[w_adr]   <= w_data;
			odd_high[w_adr]  <= w_data;
			even_low[w_adr]  <= w_data;
			even_high[w_adr] <= w_data;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			r_data1 <= '0;
			r_data2 <= '0;
		end else if (reneven) begin
			// even has priority
			r_data1 <= even_low[r_adr1];
			r_data2 <= even_high[r_adr2];
		end else if (renodd) begin
			r_data1 <= odd_low[r_adr1];
			r_data2 <= odd_high[r_adr2];
		end
	end

endmodule

`default_nettype wire

// File: hdl/gem_cluster_intake.sv
`default_nettype none

module gem_cluster_intake
	import gem_pkg::*;
	import csc_pkg::*;
#(
	parameter int ALCT_HOLD = 4
) (
	input  logic         clock,
	input  logic         arst_n,
	input  logic         alct_valid,
	input  alct_t        alct,
	input  logic         cluster_valid,
	input  gem_cluster_t cluster,
	output logic         rd_odd,
	output logic         rd_even,
	output roll_t        rd_adr,
	output logic         req_valid,
	output match_req_t   req
);

	localparam int AGE_W = $clog2(ALCT_HOLD + 1);

	// Edges since the held ALCT, parked at ALCT_HOLD when nothing is held
	logic [AGE_W-1:0] alct_age;
	wg_t              held_keywire;
	logic             pair_ok;
	wg_t              pair_keywire;
	logic             take;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			alct_age <= AGE_W'(ALCT_HOLD);
		end else if (alct_valid) begin
			alct_age <= AGE_W'(1);
		end else if (alct_age < AGE_W'(ALCT_HOLD)) begin
			alct_age <= alct_age + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (alct_valid) begin
			held_keywire <= alct.keywire;
		end
	end

	// ALCT arriving on the same edge pairs directly
	always_comb begin
		if (alct_valid) begin
			pair_ok      = 1'b1;
			pair_keywire = alct.keywire;
		end else begin
			pair_ok      = alct_age < AGE_W'(ALCT_HOLD);
			pair_keywire = held_keywire;
		end
	end

	assign take = cluster_valid & pair_ok;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			req_valid <= 1'b0;
			rd_odd    <= 1'b0;
			rd_even   <= 1'b0;
		end else begin
			req_valid <= take;
			rd_odd    <= take & cluster.odd;
			rd_even   <= take & ~cluster.odd;
		end
	end

	always_ff @(posedge clock) begin
		req.cluster <= cluster;
		req.keywire <= pair_keywire;
		rd_adr      <= cluster.roll;
	end

endmodule

`default_nettype wire

// File: hdl/csc_pkg.sv
`default_nettype none

package csc_pkg;

	import gem_pkg::*;

	// CSC wiregroup number
	typedef logic [6:0] wg_t;

	localparam wg_t WG_MAX = 7'd127;

	typedef struct packed {
		wg_t keywire;
	} alct_t;

	// Wiregroup range, both ends included
	typedef struct packed {
		wg_t low;
		wg_t high;
	} wg_window_t;

	// Cluster paired with the held ALCT
	typedef struct packed {
		gem_cluster_t cluster;
		wg_t          keywire;
	} match_req_t;

	typedef struct packed {
		logic       matched;
		roll_t      roll;
		logic       odd;
		wg_t        keywire;
		wg_window_t window;
	} match_result_t;

	typedef logic [15:0] match_count_t;

endpackage

`default_nettype wire

// File: hdl/gem_pkg.sv
`default_nettype none

package gem_pkg;

	// Eta roll index, also the table address
	typedef logic [2:0] roll_t;

	localparam int NUM_ROLLS = 8;

	// One GEM cluster
	typedef struct packed {
		logic  odd;
		roll_t roll;
	} gem_cluster_t;

endpackage

`default_nettype wire
